//--- Bender.yml
package:
  name: trs_io

sources:
  - design/esp_link_pkg.sv
  - design/z80_bus_pkg.sv
  - design/spi_byte_port.sv
  - design/esp_cmd_parser.sv
  - design/esp_regs.sv
  - design/z80_io_decoder.sv
  - design/trs_io_top.sv
  - target: test
    files:
      - tests/trs_io_checker.sv
      - tests/tb_trs_io.sv

//--- all.f
design/esp_link_pkg.sv
design/z80_bus_pkg.sv
design/spi_byte_port.sv
design/esp_cmd_parser.sv
design/esp_regs.sv
design/z80_io_decoder.sv
design/trs_io_top.sv
tests/trs_io_checker.sv
tests/tb_trs_io.sv

//--- design/esp_cmd_parser.sv
`timescale 1ns/1ns

module esp_cmd_parser (
  input  logic                clk,
  input  logic                rst,
  input  logic [7:0]          rx_byte,
  input  logic                rx_valid,
  input  logic                tx_busy,    // port still sending a reply
  output esp_link_pkg::cmd_t  cmd,
  output logic [7:0]          param,
  output logic                action,
  output logic                reply_arm,
  output logic                rx_enable
);

  import esp_link_pkg::*;

  typedef enum logic {
    idle,
    read_param
  } state_t;

  state_t state;

  always_ff @(posedge clk) begin
    if (rst) begin
      state     <= idle;
      cmd       <= get_cookie;
      action    <= 1'b0;
      reply_arm <= 1'b0;
    end else begin
      action    <= 1'b0;  // single cycle strobes
      reply_arm <= 1'b0;
      if (rx_valid) begin
        case (state)
          idle: begin
            case (rx_byte)
              get_cookie, get_version, get_printer_byte, abus_read, get_config: begin
                cmd       <= cmd_t'(rx_byte);
                action    <= 1'b1;  // regs pick the reply
                reply_arm <= 1'b1;  // port sends it next byte
              end
              set_led: begin
                cmd   <= set_led;
                state <= read_param;  // one param byte follows
              end
              default: ;  // unknown codes ignored
            endcase
          end
          read_param: begin
            action <= 1'b1;
            state  <= idle;
          end
        endcase
      end
    end
  end

  // param byte latched alongside the action strobe
  always_ff @(posedge clk) begin
    if (rx_valid && state == read_param) param <= rx_byte;
  end

  // hold off parsing from arm until the last reply bit is out
  assign rx_enable = !(reply_arm || tx_busy);

endmodule

//--- design/esp_link_pkg.sv
package esp_link_pkg;

  // command byte sent by the ESP as the first byte of a message
  typedef enum logic [7:0] {
    get_cookie       = 8'd0,
    get_version      = 8'd15,
    get_printer_byte = 8'd16,
    abus_read        = 8'd18,
    set_led          = 8'd26,
    get_config       = 8'd27
  } cmd_t;

  // fixed id so the ESP can tell the card is alive
  localparam logic [7:0] COOKIE = 8'haf;

  // firmware version, packed major:minor into one reply byte
  localparam logic [2:0] VERSION_MAJOR = 3'd0;
  localparam logic [4:0] VERSION_MINOR = 5'd3;

  // status leds
  // red is the lsb, so set_led param bits 2:0 map straight on
  typedef struct packed {
    logic blue;
    logic green;
    logic red;
  } led_t;

endpackage

//--- design/esp_regs.sv
`timescale 1ns/1ns

module esp_regs (
  input  logic               clk,
  input  logic               rst,
  input  esp_link_pkg::cmd_t cmd,
  input  logic [7:0]         param,
  input  logic               action,
  input  logic [3:0]         conf,          // config switches
  input  logic [7:0]         printer_byte,  // last byte the z80 printed
  input  logic [7:0]         abus_low,      // low addr byte of last access
  output esp_link_pkg::led_t leds,
  output logic [7:0]         tx_byte
);

  import esp_link_pkg::*;

  logic [7:0] reply_sel;

  // reply value per command
  always_comb begin
    case (cmd)
      get_cookie:       reply_sel = COOKIE;
      get_version:      reply_sel = {VERSION_MAJOR, VERSION_MINOR};
      get_printer_byte: reply_sel = printer_byte;
      abus_read:        reply_sel = abus_low;
      get_config:       reply_sel = {4'b0000, conf};
      default:          reply_sel = 8'h00;
    endcase
  end

  // snapshot at action time, stable while the port shifts it out
  always_ff @(posedge clk) begin
    if (action) tx_byte <= reply_sel;
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      leds <= '0;  // all off
    end else if (action && cmd == set_led) begin
      leds <= led_t'(param[2:0]);  // bit0 red, bit1 green, bit2 blue
    end
  end

endmodule

//--- design/spi_byte_port.sv
`timescale 1ns/1ns

module spi_byte_port (
  input  logic       clk,
  input  logic       rst,
  input  logic       sck,
  input  logic       cs_n,
  input  logic       mosi,
  input  logic       rx_enable,  // low while a reply goes out
  input  logic       reply_arm,  // load tx_byte on next falling sck
  input  logic [7:0] tx_byte,
  output logic       miso,
  output logic [7:0] rx_byte,
  output logic       rx_valid,
  output logic       tx_busy
);

  logic [2:0] sck_sync;  // 2 sync stages + 1 for edge detect
  logic [1:0] cs_sync;
  logic [1:0] mosi_sync;
  logic       cs_active;
  logic       sck_rise;
  logic       sck_fall;
  logic [2:0] bit_cnt;   // rx bit position within byte
  logic       armed;     // reply waiting for its falling edge
  logic [3:0] tx_cnt;    // reply bits still on the wire
  logic [7:0] tx_shift;

  always_ff @(posedge clk) begin
    if (rst) begin
      sck_sync <= '0;
      cs_sync  <= '1;  // deselected
    end else begin
      sck_sync <= {sck_sync[1:0], sck};
      cs_sync  <= {cs_sync[0], cs_n};
    end
  end

  always_ff @(posedge clk) mosi_sync <= {mosi_sync[0], mosi};

  assign cs_active = ~cs_sync[1];
  assign sck_rise  = sck_sync[1] & ~sck_sync[2];
  assign sck_fall  = ~sck_sync[1] & sck_sync[2];

  // mode 0, msb first, sample on rising sck
  always_ff @(posedge clk) begin
    if (rst) begin
      bit_cnt  <= '0;
      rx_valid <= 1'b0;
    end else begin
      rx_valid <= 1'b0;
      if (!cs_active) begin
        bit_cnt <= '0;  // realign on every frame
      end else if (sck_rise) begin
        bit_cnt  <= bit_cnt + 3'd1;
        rx_valid <= (bit_cnt == 3'd7) && rx_enable;  // dummy bytes dropped
      end
    end
  end

  always_ff @(posedge clk) begin
    if (cs_active && sck_rise) rx_byte <= {rx_byte[6:0], mosi_sync[1]};
  end

  // reply: load on the first falling edge after arm, then 7 more shifts
  always_ff @(posedge clk) begin
    if (rst || !cs_active) begin
      armed  <= 1'b0;
      tx_cnt <= '0;
    end else begin
      if (reply_arm) armed <= 1'b1;
      if (sck_fall) begin
        if (armed) begin
          armed  <= 1'b0;
          tx_cnt <= 4'd8;
        end else if (tx_cnt != 4'd0) begin
          tx_cnt <= tx_cnt - 4'd1;  // reaches 0 after lsb was sampled
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (cs_active && sck_fall) begin
      if (armed) tx_shift <= tx_byte;
      else tx_shift <= {tx_shift[6:0], 1'b0};
    end
  end

  assign tx_busy = armed || (tx_cnt != 4'd0);
  assign miso    = cs_active && (tx_cnt != 4'd0) && tx_shift[7];  // 0 when idle

endmodule

//--- design/trs_io_top.sv
`timescale 1ns/1ns

module trs_io_top #(
  parameter int REQ_PULSE_CYCLES = 50
) (
  input  logic                      clk,
  input  logic                      rst,
  input  z80_bus_pkg::z80_bus_t     bus,
  input  logic                      sck,
  input  logic                      cs_n,
  input  logic                      mosi,
  input  logic                      esp_done,
  input  logic [3:0]                conf,
  output logic                      miso,
  output logic                      esp_req,
  output z80_bus_pkg::esp_status_t  esp_s,
  output logic                      z80_wait,
  output esp_link_pkg::led_t        leds
);

  import esp_link_pkg::*;

  logic [7:0] rx_byte;
  logic       rx_valid;
  logic       rx_enable;
  logic       reply_arm;
  logic       tx_busy;
  logic [7:0] tx_byte;
  cmd_t       cmd;
  logic [7:0] param;
  logic       action;
  logic [7:0] printer_byte;
  logic [7:0] abus_low;

  spi_byte_port i_spi_byte_port (
    .clk, .rst, .sck, .cs_n, .mosi, .rx_enable, .reply_arm, .tx_byte,
    .miso, .rx_byte, .rx_valid, .tx_busy
  );

  esp_cmd_parser i_esp_cmd_parser (
    .clk, .rst, .rx_byte, .rx_valid, .tx_busy,
    .cmd, .param, .action, .reply_arm, .rx_enable
  );

  esp_regs i_esp_regs (
    .clk, .rst, .cmd, .param, .action, .conf, .printer_byte, .abus_low,
    .leds, .tx_byte
  );

  z80_io_decoder #(
    .REQ_PULSE_CYCLES(REQ_PULSE_CYCLES)
  ) i_z80_io_decoder (
    .clk, .rst, .bus, .esp_done,
    .esp_req, .z80_wait, .esp_s, .printer_byte, .abus_low
  );

endmodule

//--- design/z80_bus_pkg.sv
package z80_bus_pkg;

  // z80 bus as seen by the card, strobes active low
  typedef struct packed {
    logic [15:0] addr;
    logic [7:0]  data;
    logic        rd_n;   // memory read
    logic        wr_n;   // memory write
    logic        in_n;   // io read
    logic        out_n;  // io write
  } z80_bus_t;

  // trs-io port, in and out
  localparam logic [7:0] TRS_IO_PORT = 8'd31;

  // frehd uses ports 0xc0..0xcf, only the high nibble is checked
  localparam logic [3:0] FREHD_PORT_HI = 4'hc;

  // memory mapped printer data register
  localparam logic [15:0] PRINTER_ADDR = 16'h37e8;

  // code on esp_s telling the ESP what the z80 is doing
  typedef enum logic [3:0] {
    trs_io_in  = 4'd0,
    trs_io_out = 4'd1,
    frehd_in   = 4'd2,
    frehd_out  = 4'd3,
    printer_wr = 4'd4,
    idle       = 4'd15
  } esp_status_t;

endpackage

//--- design/z80_io_decoder.sv
`timescale 1ns/1ns

module z80_io_decoder #(
  parameter int REQ_PULSE_CYCLES = 50  // esp_req width in clk cycles
) (
  input  logic                      clk,
  input  logic                      rst,
  input  z80_bus_pkg::z80_bus_t     bus,
  input  logic                      esp_done,
  output logic                      esp_req,
  output logic                      z80_wait,
  output z80_bus_pkg::esp_status_t  esp_s,
  output logic [7:0]                printer_byte,
  output logic [7:0]                abus_low
);

  import z80_bus_pkg::*;

  localparam int CNT_W = $clog2(REQ_PULSE_CYCLES + 1);

  z80_bus_t   bus_q;         // sampled bus
  logic       access;
  logic       access_q;
  logic       access_edge;
  logic       sel_trs_io_in;
  logic       sel_trs_io_out;
  logic       sel_frehd_in;
  logic       sel_frehd_out;
  logic       sel_printer;
  logic       esp_sel;
  logic [2:0] done_sync;
  logic       done_rise;
  logic       printer_busy;
  logic [CNT_W-1:0] req_cnt;

  always_ff @(posedge clk) bus_q <= bus;

  assign access = !(bus_q.rd_n && bus_q.wr_n && bus_q.in_n && bus_q.out_n);

  always_ff @(posedge clk) begin
    if (rst) access_q <= 1'b0;
    else access_q <= access;
  end

  assign access_edge = access && !access_q;  // start of any strobe

  // selects, valid while the strobe is held
  assign sel_trs_io_in  = (bus_q.addr[7:0] == TRS_IO_PORT) && !bus_q.in_n;
  assign sel_trs_io_out = (bus_q.addr[7:0] == TRS_IO_PORT) && !bus_q.out_n;
  assign sel_frehd_in   = (bus_q.addr[7:4] == FREHD_PORT_HI) && !bus_q.in_n;
  assign sel_frehd_out  = (bus_q.addr[7:4] == FREHD_PORT_HI) && !bus_q.out_n;
  assign sel_printer    = (bus_q.addr == PRINTER_ADDR) && !bus_q.wr_n;
  assign esp_sel = sel_trs_io_in || sel_trs_io_out || sel_frehd_in || sel_frehd_out ||
                   sel_printer;

  // done comes from the ESP clock domain
  always_ff @(posedge clk) begin
    if (rst) done_sync <= '0;
    else done_sync <= {done_sync[1:0], esp_done};
  end

  assign done_rise = done_sync[1] && !done_sync[2];

  always_ff @(posedge clk) begin
    if (rst) begin
      esp_req      <= 1'b0;
      req_cnt      <= '0;
      z80_wait     <= 1'b0;
      printer_busy <= 1'b0;
      printer_byte <= 8'h00;
    end else begin
      if (access_edge && esp_sel) begin
        esp_req <= 1'b1;  // new access restarts the pulse
        req_cnt <= CNT_W'(REQ_PULSE_CYCLES);
        if (sel_printer) begin
          printer_busy <= 1'b1;  // no wait, the byte is buffered
          printer_byte <= bus_q.data;
        end else begin
          z80_wait <= 1'b1;  // stall z80 until ESP answers
        end
      end else begin
        if (req_cnt == CNT_W'(1)) esp_req <= 1'b0;
        if (req_cnt != '0) req_cnt <= req_cnt - CNT_W'(1);
        if (done_rise) begin
          z80_wait     <= 1'b0;
          printer_busy <= 1'b0;
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (access_edge) abus_low <= bus_q.addr[7:0];
  end

  // port strobes win over a pending printer byte
  always_comb begin
    if (sel_trs_io_in) esp_s = trs_io_in;
    else if (sel_trs_io_out) esp_s = trs_io_out;
    else if (sel_frehd_in) esp_s = frehd_in;
    else if (sel_frehd_out) esp_s = frehd_out;
    else if (printer_busy) esp_s = printer_wr;
    else esp_s = idle;
  end

endmodule

//--- tests/tb_trs_io.sv
`timescale 1ns/1ns

module tb_trs_io;

  import esp_link_pkg::*;
  import z80_bus_pkg::*;

  localparam int REQ_CYCLES = 20;  // req pulse width under test
  localparam int HALF       = 6;   // sck half period in clk cycles
  localparam int WAIT_LIMIT = 200;

  logic        clk;
  logic        rst;
  z80_bus_t    bus;
  logic        sck, cs_n, mosi, esp_done;
  logic [3:0]  conf;
  logic        miso, esp_req, z80_wait;
  esp_status_t esp_s;
  led_t        leds;
  logic [7:0]  model_printer_byte;  // what the card should hold
  logic [7:0]  model_abus_low;
  logic [7:0]  led_param;

  trs_io_top #(.REQ_PULSE_CYCLES(REQ_CYCLES)) i_trs_io_top (
    .clk, .rst, .bus, .sck, .cs_n, .mosi, .esp_done, .conf,
    .miso, .esp_req, .esp_s, .z80_wait, .leds
  );

  trs_io_checker i_trs_io_checker (
    .clk, .sck, .cs_n, .miso, .esp_req, .z80_wait, .esp_s, .leds
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  // reply byte the ESP should read back for a command
  function automatic logic [7:0] expected_reply(input cmd_t c, input logic [7:0] pb,
                                                input logic [7:0] al, input logic [3:0] sw);
    case (c)
      get_cookie:       return 8'haf;
      get_version:      return 8'h03;  // major 0, minor 3
      get_printer_byte: return pb;
      abus_read:        return al;
      get_config:       return {4'h0, sw};
      default:          return 8'h00;
    endcase
  endfunction

  task automatic tick(input int n);
    repeat (n) @(posedge clk);
    #2;  // drive just after the edge
  endtask

  task automatic spi_begin();
    cs_n = 1'b0;
    tick(HALF);
  endtask

  task automatic spi_end();
    tick(HALF);
    cs_n = 1'b1;
    mosi = 1'b0;
    tick(2 * HALF);
  endtask

  // mode 0, msb first, falls at the end of every bit
  task automatic spi_byte(input logic [7:0] b);
    for (int i = 7; i >= 0; i--) begin
      mosi = b[i];
      tick(HALF);
      sck = 1'b1;
      tick(HALF);
      sck = 1'b0;
    end
  endtask

  // command byte then a dummy byte that clocks the reply out
  task automatic check_reply(input string name, input cmd_t c);
    spi_begin();
    spi_byte(c);
    spi_byte(8'h00);
    spi_end();
    i_trs_io_checker.expect_value(name, "reply",
      expected_reply(c, model_printer_byte, model_abus_low, conf));
    tick(1);
  endtask

  task automatic set_leds(input logic [7:0] p);
    spi_begin();
    spi_byte(set_led);
    spi_byte(p);  // param byte
    spi_end();
    i_trs_io_checker.expect_value("set_led", "leds", p[2:0]);
    tick(1);
  endtask

  function automatic logic level_of(input int sel);
    return (sel == 0) ? esp_req : z80_wait;
  endfunction

  // sel 0 esp_req, 1 z80_wait
  task automatic wait_level(input int sel, input logic level, input string what);
    int n;
    n = 0;
    while (level_of(sel) !== level && n < WAIT_LIMIT) begin
      tick(1);
      n++;
    end
    if (level_of(sel) !== level) i_trs_io_checker.report_error({"timeout waiting for ", what});
  endtask

  task automatic port_access(input string name, input logic [7:0] port, input bit is_out,
                             input int code);
    bus.addr = {8'($urandom), port};  // upper byte ignored by port decode
    bus.data = 8'($urandom);
    tick(1);
    if (is_out) bus.out_n = 1'b0;
    else bus.in_n = 1'b0;
    model_abus_low = port;
    wait_level(0, 1'b1, {name, " esp_req rise"});
    wait_level(1, 1'b1, {name, " z80_wait rise"});
    i_trs_io_checker.expect_value({name, " esp_s"}, "esp_s", code);  // strobe still held
    wait_level(0, 1'b0, {name, " esp_req fall"});
    i_trs_io_checker.expect_value({name, " req width"}, "req_width", REQ_CYCLES);
    esp_done = 1'b1;
    wait_level(1, 1'b0, {name, " z80_wait fall"});
    bus.in_n  = 1'b1;
    bus.out_n = 1'b1;
    esp_done  = 1'b0;
    tick(2);
    check_reply({name, " abus_read"}, abus_read);
  endtask

  task automatic printer_write(input logic [7:0] data);
    bus.addr = 16'h37e8;
    bus.data = data;
    tick(1);
    bus.wr_n = 1'b0;
    model_printer_byte = data;
    model_abus_low     = 8'he8;
    wait_level(0, 1'b1, "printer esp_req rise");
    i_trs_io_checker.expect_value("printer z80_wait", "z80_wait", 0);  // no stall
    tick(2);
    bus.wr_n = 1'b1;
    tick(2);
    i_trs_io_checker.expect_value("printer busy esp_s", "esp_s", 4);
    wait_level(0, 1'b0, "printer esp_req fall");
    esp_done = 1'b1;
    tick(6);  // busy clears within 4 cycles of done
    i_trs_io_checker.expect_value("printer done esp_s", "esp_s", 15);
    esp_done = 1'b0;
    tick(2);
    check_reply("get_printer_byte", get_printer_byte);
  endtask

  task automatic stray_port();
    logic [7:0] p;
    p = 8'($urandom);
    while (p == 8'd31 || p[7:4] == 4'hc) p = 8'($urandom);
    bus.addr = {8'h00, p};
    tick(1);
    bus.out_n = 1'b0;
    model_abus_low = p;
    tick(8);
    i_trs_io_checker.expect_value("stray port esp_req", "esp_req", 0);
    i_trs_io_checker.expect_value("stray port z80_wait", "z80_wait", 0);
    tick(1);
    bus.out_n = 1'b1;
    tick(2);
  endtask

  initial begin
    void'($urandom(18));
    rst  = 1'b1;
    bus  = {16'h0000, 8'h00, 4'b1111};  // all strobes idle
    sck  = 1'b0;
    cs_n = 1'b1;
    mosi = 1'b0;
    esp_done = 1'b0;
    conf = 4'h0;
    model_printer_byte = 8'h00;
    model_abus_low     = 8'h00;
    tick(4);
    rst = 1'b0;
    tick(2);
    i_trs_io_checker.expect_value("reset esp_req", "esp_req", 0);
    i_trs_io_checker.expect_value("reset z80_wait", "z80_wait", 0);
    i_trs_io_checker.expect_value("reset leds", "leds", 0);
    i_trs_io_checker.expect_value("reset esp_s", "esp_s", 15);
    tick(1);
    check_reply("get_cookie", get_cookie);
    check_reply("get_version", get_version);
    repeat (3) begin
      conf = 4'($urandom);
      check_reply("get_config", get_config);
    end
    repeat (3) begin
      led_param = 8'($urandom);
      set_leds(led_param);
    end
    port_access("out port 31", 8'd31, 1'b1, 1);
    port_access("in port 31", 8'd31, 1'b0, 0);
    port_access("frehd in", {4'hc, 4'($urandom)}, 1'b0, 2);
    port_access("frehd out", {4'hc, 4'($urandom)}, 1'b1, 3);
    printer_write(8'($urandom));
    stray_port();
    tick(4);  // let the last compares drain
    i_trs_io_checker.report_counts();
    if (i_trs_io_checker.fail_cnt == 0) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

endmodule

//--- tests/trs_io_checker.sv
`timescale 1ns/1ns

module trs_io_checker (
  input logic       clk,
  input logic       sck,
  input logic       cs_n,
  input logic       miso,
  input logic       esp_req,
  input logic       z80_wait,
  input logic [3:0] esp_s,
  input logic [2:0] leds
);

  string      name_q[$];  // pending checks, one entry each
  string      port_q[$];
  int         exp_q[$];
  int         pass_cnt = 0;
  int         fail_cnt = 0;
  int         req_run = 0;     // cycles esp_req has been high
  int         last_width = 0;  // width of the last finished pulse
  logic [7:0] rx_shift;        // last byte seen on miso

  // ESP side samples miso on rising sck
  always @(posedge sck) begin
    if (!cs_n) rx_shift <= {rx_shift[6:0], miso};
  end

  task automatic expect_value(input string name, input string port, input int exp);
    name_q.push_back(name);
    port_q.push_back(port);
    exp_q.push_back(exp);
  endtask

  task automatic report_error(input string msg);
    fail_cnt++;
    $display("%s", msg);
  endtask

  task automatic report_counts();
    $display("checks done: %0d passed, %0d failed", pass_cnt, fail_cnt);
  endtask

  // outputs settle well before the falling clock
  always @(negedge clk) begin : compare
    string       name;
    string       port;
    int          exp;
    logic [31:0] act;
    logic        known;
    if (esp_req) begin
      req_run = req_run + 1;
    end else if (req_run != 0) begin
      last_width = req_run;  // pulse just ended
      req_run = 0;
    end
    while (port_q.size() != 0) begin
      name  = name_q.pop_front();
      port  = port_q.pop_front();
      exp   = exp_q.pop_front();
      known = 1'b1;
      act   = '0;
      if (port == "reply") act = rx_shift;
      else if (port == "req_width") act = last_width;
      else if (port == "esp_req") act = esp_req;
      else if (port == "z80_wait") act = z80_wait;
      else if (port == "esp_s") act = esp_s;
      else if (port == "leds") act = leds;
      else known = 1'b0;
      if (!known) begin
        report_error({"check ", name, " names an unknown output ", port});
      end else if (act === exp) begin
        pass_cnt++;
        $display("[PASS] %s", name);
      end else begin
        fail_cnt++;
        $display("[FAIL] %s expected 0x%0h actual 0x%0h", name, exp, act);
      end
    end
  end

endmodule
